//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= tb_gt_drp_subsys
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
rtl/drp_pkg.sv
rtl/drp_rmw_seq.sv
rtl/drp_arbiter.sv
rtl/gt_drp_subsys.sv
tb/drp_target_model.sv
tb/tb_gt_drp_subsys.sv

//--- rtl/drp_arbiter.sv
`timescale 1ns/1ps

module drp_arbiter #
(
    parameter int LANES = 2
)
(
    input  logic                                        DRP_CLK,
    input  logic                                        DRP_RST_N,
    input  logic [LANES-1:0]                            req,
    input  logic [LANES-1:0][drp_pkg::DRP_ADDR_W-1:0]   lane_addr,
    input  logic [LANES-1:0]                            lane_en,
    input  logic [LANES-1:0][drp_pkg::DRP_DATA_W-1:0]   lane_di,
    input  logic [LANES-1:0]                            lane_we,
    input  logic [drp_pkg::DRP_DATA_W-1:0]              drp_do,
    input  logic                                        drp_rdy,

    output logic [LANES-1:0]                            gnt,
    output logic [LANES-1:0]                            lane_rdy,
    output logic [drp_pkg::DRP_DATA_W-1:0]              rd_data,
    output logic [drp_pkg::DRP_ADDR_W-1:0]              drp_addr,
    output logic                                        drp_en,
    output logic [drp_pkg::DRP_DATA_W-1:0]              drp_di,
    output logic                                        drp_we
);

    localparam int OWN_W = (LANES > 1) ? $clog2(LANES) : 1;

    drp_pkg::arb_state_e arb_state;
    logic [OWN_W-1:0]    owner;
    logic [OWN_W-1:0]    rr_ptr;      // last lane that owned the port
    logic [OWN_W-1:0]    next_owner;

    // first requesting lane after the last owner, wrapping around
    function automatic logic [OWN_W-1:0] rr_pick(input logic [LANES-1:0] r,
                                                 input logic [OWN_W-1:0] last);
        logic [OWN_W-1:0] pick;
        logic             found;
        int               cand;
        pick  = last;
        found = 1'b0;
        for (int k = 1; k <= LANES; k++)
        begin
            cand = (int'(last) + k) % LANES;
            if (!found && r[cand])
            begin
                pick  = OWN_W'(cand);
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    assign next_owner = rr_pick(req, rr_ptr);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ownership
    always_ff @(posedge DRP_CLK)
    begin
        if (!DRP_RST_N)
        begin
            arb_state <= drp_pkg::arb_free;
            owner     <= '0;
            rr_ptr    <= OWN_W'(LANES - 1);   // lane 0 wins first
        end
        else
        begin
            case (arb_state)
                drp_pkg::arb_free:
                begin
                    if (|req)
                    begin
                        arb_state <= drp_pkg::arb_owned;
                        owner     <= next_owner;
                    end
                end
                default:
                begin
                    if (!req[owner])
                    begin
                        arb_state <= drp_pkg::arb_free;
                        rr_ptr    <= owner;
                    end
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // port steering
    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            gnt[i]      = (arb_state == drp_pkg::arb_owned) && (owner == OWN_W'(i));
            lane_rdy[i] = gnt[i] && drp_rdy;   // non-owners never see ready
        end
    end

    assign rd_data  = drp_do;
    assign drp_addr = (arb_state == drp_pkg::arb_owned) ? lane_addr[owner] : '0;
    assign drp_en   = (arb_state == drp_pkg::arb_owned) && lane_en[owner];
    assign drp_di   = (arb_state == drp_pkg::arb_owned) ? lane_di[owner] : '0;
    assign drp_we   = (arb_state == drp_pkg::arb_owned) && lane_we[owner];

    a_one_grant: assert property (@(posedge DRP_CLK) disable iff (!DRP_RST_N)
        $onehot0(gnt))
        else $error("more than one lane granted");

    a_no_en_free: assert property (@(posedge DRP_CLK) disable iff (!DRP_RST_N)
        (arb_state == drp_pkg::arb_free) |-> !drp_en)
        else $error("drp enable seen with no owner");

endmodule

//--- rtl/drp_pkg.sv
package drp_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus widths and address map
    localparam int DRP_ADDR_W = 9;
    localparam int DRP_DATA_W = 16;

    localparam logic [DRP_ADDR_W-1:0] LANE_SPAN = 9'h080;  // one channel window per lane

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field table, one word per entry
    localparam int FIELD_COUNT = 2;

    localparam logic [DRP_ADDR_W-1:0] RX_DATAWIDTH_OFS = 9'h011;
    localparam logic [DRP_ADDR_W-1:0] TX_DATAWIDTH_OFS = 9'h06B;

    localparam logic [DRP_DATA_W-1:0] RX_DATAWIDTH_MASK = 16'hF7FF;
    localparam logic [DRP_DATA_W-1:0] TX_DATAWIDTH_MASK = 16'hFFEF;

    // the x16 setting of both fields is all zeros
    localparam logic [DRP_DATA_W-1:0] RX_X20_BITS = 16'h0800;
    localparam logic [DRP_DATA_W-1:0] TX_X20_BITS = 16'h0010;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state encodings
    typedef enum logic [2:0]
    {
        st_idle       = 3'd0,
        st_load       = 3'd1,
        st_read       = 3'd2,
        st_read_wait  = 3'd3,
        st_write      = 3'd4,
        st_write_wait = 3'd5,
        st_done       = 3'd6
    } drp_state_e;

    typedef enum logic
    {
        arb_free  = 1'b0,
        arb_owned = 1'b1
    } arb_state_e;

endpackage

//--- rtl/drp_rmw_seq.sv
`timescale 1ns/1ps

module drp_rmw_seq #
(
    parameter int                              LOAD_CNT_MAX = 1,
    parameter logic [drp_pkg::DRP_ADDR_W-1:0]  CHAN_BASE    = '0
)
(
    input  logic                               DRP_CLK,
    input  logic                               DRP_RST_N,
    input  logic                               start,
    input  logic                               x16,
    input  logic                               gnt,
    input  logic                               rdy,
    input  logic [drp_pkg::DRP_DATA_W-1:0]     rd_data,

    output logic                               req,
    output logic [drp_pkg::DRP_ADDR_W-1:0]     addr,
    output logic                               en,
    output logic [drp_pkg::DRP_DATA_W-1:0]     di,
    output logic                               we,
    output logic                               done,
    output drp_pkg::drp_state_e                state
);

    localparam int CNT_W = (LOAD_CNT_MAX > 0) ? $clog2(LOAD_CNT_MAX + 1) : 1;
    localparam int IDX_W = (drp_pkg::FIELD_COUNT > 1) ? $clog2(drp_pkg::FIELD_COUNT) : 1;

    logic                           start_reg1;
    logic                           start_reg2;
    logic                           x16_reg1;
    logic                           x16_reg2;
    logic                           rdy_reg1;
    logic                           rdy_reg2;
    logic [drp_pkg::DRP_DATA_W-1:0] do_reg1;
    logic [drp_pkg::DRP_DATA_W-1:0] do_reg2;

    logic [CNT_W-1:0]               load_cnt;
    logic                           load_full;
    logic [IDX_W-1:0]               idx;

    logic [drp_pkg::DRP_ADDR_W-1:0] field_ofs;
    logic [drp_pkg::DRP_DATA_W-1:0] field_mask;
    logic [drp_pkg::DRP_DATA_W-1:0] field_set;
    logic [drp_pkg::DRP_DATA_W-1:0] di_reg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input registers
    always_ff @(posedge DRP_CLK)
    begin
        if (!DRP_RST_N)
        begin
            start_reg1 <= 1'b0;
            start_reg2 <= 1'b0;
            x16_reg1   <= 1'b0;
            x16_reg2   <= 1'b0;
            rdy_reg1   <= 1'b0;
            rdy_reg2   <= 1'b0;
        end
        else
        begin
            start_reg1 <= start;
            start_reg2 <= start_reg1;
            x16_reg1   <= x16;
            x16_reg2   <= x16_reg1;
            rdy_reg1   <= rdy;
            rdy_reg2   <= rdy_reg1;
        end
    end

    always_ff @(posedge DRP_CLK)
    begin
        do_reg1 <= rd_data;
        do_reg2 <= do_reg1;   // lines up with rdy_reg2
    end

    // counts up while in load and holds at the limit
    always_ff @(posedge DRP_CLK)
    begin
        if (!DRP_RST_N)
            load_cnt <= '0;
        else if (state != drp_pkg::st_load)
            load_cnt <= '0;
        else if (!load_full)
            load_cnt <= load_cnt + 1'b1;
    end

    assign load_full = (load_cnt == CNT_W'(LOAD_CNT_MAX));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field table
    always_comb
    begin
        case (idx)
            IDX_W'(0):
            begin
                field_ofs  = drp_pkg::RX_DATAWIDTH_OFS;
                field_mask = drp_pkg::RX_DATAWIDTH_MASK;
                field_set  = x16_reg2 ? '0 : drp_pkg::RX_X20_BITS;
            end
            default:
            begin
                field_ofs  = drp_pkg::TX_DATAWIDTH_OFS;
                field_mask = drp_pkg::TX_DATAWIDTH_MASK;
                field_set  = x16_reg2 ? '0 : drp_pkg::TX_X20_BITS;
            end
        endcase
    end

    // the new word is formed when the read data arrives
    always_ff @(posedge DRP_CLK)
    begin
        if ((state == drp_pkg::st_read_wait) && rdy_reg2)
            di_reg <= (do_reg2 & field_mask) | field_set;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer FSM
    always_ff @(posedge DRP_CLK)
    begin
        if (!DRP_RST_N)
        begin
            state <= drp_pkg::st_idle;
            idx   <= '0;
        end
        else
        begin
            case (state)
                drp_pkg::st_idle:
                begin
                    idx <= '0;
                    if (start_reg2)
                        state <= drp_pkg::st_load;
                end
                drp_pkg::st_load:
                begin
                    if (load_full && gnt)
                        state <= drp_pkg::st_read;
                end
                drp_pkg::st_read:
                    state <= drp_pkg::st_read_wait;
                drp_pkg::st_read_wait:
                begin
                    if (rdy_reg2)
                        state <= drp_pkg::st_write;
                end
                drp_pkg::st_write:
                    state <= drp_pkg::st_write_wait;
                drp_pkg::st_write_wait:
                begin
                    if (rdy_reg2)
                        state <= drp_pkg::st_done;
                end
                drp_pkg::st_done:
                begin
                    if (idx == IDX_W'(drp_pkg::FIELD_COUNT - 1))
                    begin
                        state <= drp_pkg::st_idle;
                        idx   <= '0;
                    end
                    else
                    begin
                        state <= drp_pkg::st_load;
                        idx   <= idx + 1'b1;
                    end
                end
                default:
                    state <= drp_pkg::st_idle;
            endcase
        end
    end

    // request covers the whole read-write pair so the arbiter keeps the grant
    assign req  = (state == drp_pkg::st_load) || (state == drp_pkg::st_read) ||
                  (state == drp_pkg::st_read_wait) || (state == drp_pkg::st_write) ||
                  (state == drp_pkg::st_write_wait);
    assign addr = CHAN_BASE + field_ofs;
    assign en   = (state == drp_pkg::st_read) || (state == drp_pkg::st_write);
    assign we   = (state == drp_pkg::st_write);
    assign di   = di_reg;
    assign done = (state == drp_pkg::st_idle);   // high while idle

    a_en_needs_gnt: assert property (@(posedge DRP_CLK) disable iff (!DRP_RST_N)
        en |-> gnt)
        else $error("drp enable raised without a grant");

    a_we_with_en: assert property (@(posedge DRP_CLK) disable iff (!DRP_RST_N)
        we |-> en)
        else $error("drp write enable raised without enable");

endmodule

//--- rtl/gt_drp_subsys.sv
`timescale 1ns/1ps

module gt_drp_subsys #
(
    parameter int LANES        = 2,
    parameter int LOAD_CNT_MAX = 1
)
(
    input  logic                               DRP_CLK,
    input  logic                               DRP_RST_N,
    input  logic [LANES-1:0]                   start,
    input  logic [LANES-1:0]                   x16,
    input  logic [drp_pkg::DRP_DATA_W-1:0]     drp_do,
    input  logic                               drp_rdy,

    output logic [drp_pkg::DRP_ADDR_W-1:0]     drp_addr,
    output logic                               drp_en,
    output logic [drp_pkg::DRP_DATA_W-1:0]     drp_di,
    output logic                               drp_we,
    output logic [LANES-1:0]                   done,
    output drp_pkg::drp_state_e [LANES-1:0]    lane_state
);

    logic [LANES-1:0]                          req;
    logic [LANES-1:0]                          gnt;
    logic [LANES-1:0]                          lane_rdy;
    logic [LANES-1:0][drp_pkg::DRP_ADDR_W-1:0] lane_addr;
    logic [LANES-1:0]                          lane_en;
    logic [LANES-1:0][drp_pkg::DRP_DATA_W-1:0] lane_di;
    logic [LANES-1:0]                          lane_we;
    logic [drp_pkg::DRP_DATA_W-1:0]            rd_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one sequencer per lane
    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        localparam logic [drp_pkg::DRP_ADDR_W-1:0] BASE = i * drp_pkg::LANE_SPAN;

        drp_rmw_seq #
        (
            .LOAD_CNT_MAX (LOAD_CNT_MAX),
            .CHAN_BASE    (BASE)
        )
        u_seq
        (
            .DRP_CLK      (DRP_CLK),
            .DRP_RST_N    (DRP_RST_N),
            .start        (start[i]),
            .x16          (x16[i]),
            .gnt          (gnt[i]),
            .rdy          (lane_rdy[i]),
            .rd_data      (rd_data),
            .req          (req[i]),
            .addr         (lane_addr[i]),
            .en           (lane_en[i]),
            .di           (lane_di[i]),
            .we           (lane_we[i]),
            .done         (done[i]),
            .state        (lane_state[i])
        );
    end

    // shared port to the quad
    drp_arbiter #
    (
        .LANES        (LANES)
    )
    u_arb
    (
        .DRP_CLK      (DRP_CLK),
        .DRP_RST_N    (DRP_RST_N),
        .req          (req),
        .lane_addr    (lane_addr),
        .lane_en      (lane_en),
        .lane_di      (lane_di),
        .lane_we      (lane_we),
        .drp_do       (drp_do),
        .drp_rdy      (drp_rdy),
        .gnt          (gnt),
        .lane_rdy     (lane_rdy),
        .rd_data      (rd_data),
        .drp_addr     (drp_addr),
        .drp_en       (drp_en),
        .drp_di       (drp_di),
        .drp_we       (drp_we)
    );

endmodule

//--- tb/drp_target_model.sv
`timescale 1ns/1ps

module drp_target_model #
(
    parameter int SEED      = 32'h2e07_5afc,
    parameter int MAX_DELAY = 6
)
(
    input  logic                           DRP_CLK,
    input  logic                           DRP_RST_N,
    input  logic [drp_pkg::DRP_ADDR_W-1:0] drp_addr,
    input  logic                           drp_en,
    input  logic [drp_pkg::DRP_DATA_W-1:0] drp_di,
    input  logic                           drp_we,
    input  logic                           bd_we,       // backdoor write from the testbench
    input  logic [drp_pkg::DRP_ADDR_W-1:0] bd_addr,
    input  logic [drp_pkg::DRP_DATA_W-1:0] bd_data,
    output logic [drp_pkg::DRP_DATA_W-1:0] drp_do,
    output logic                           drp_rdy,
    output logic                           protocol_err
);

    localparam int AW = drp_pkg::DRP_ADDR_W;
    localparam int DW = drp_pkg::DRP_DATA_W;

    logic [DW-1:0] mem [0:(1 << AW)-1];

    // inputs are taken at the rising edge, outputs change 1 ns later
    initial
    begin : target
        int            seed;
        int            cnt;
        logic          pending;
        logic          en_s;
        logic          we_s;
        logic [AW-1:0] addr_s;
        logic [DW-1:0] di_s;
        logic          bd_we_s;
        logic [AW-1:0] bd_addr_s;
        logic [DW-1:0] bd_data_s;
        logic          acc_we;
        logic [AW-1:0] acc_addr;
        logic [DW-1:0] acc_di;
        seed         = SEED;
        cnt          = 0;
        pending      = 1'b0;
        acc_we       = 1'b0;
        acc_addr     = '0;
        acc_di       = '0;
        drp_do       = '0;
        drp_rdy      = 1'b0;
        protocol_err = 1'b0;
        forever
        begin
            @(posedge DRP_CLK);
            en_s      = (drp_en === 1'b1);
            we_s      = (drp_we === 1'b1);
            addr_s    = drp_addr;
            di_s      = drp_di;
            bd_we_s   = (bd_we === 1'b1);
            bd_addr_s = bd_addr;
            bd_data_s = bd_data;
            #1;
            drp_rdy = 1'b0;
            if (!DRP_RST_N)
            begin
                pending = 1'b0;
                for (int a = 0; a < (1 << AW); a++)
                    mem[a] = DW'(a * 257) ^ 16'h3c96;   // every address bit shows in the word
            end
            else
            begin
                if (bd_we_s)
                    mem[bd_addr_s] = bd_data_s;
                if (en_s && pending)
                begin
                    $display("target model: enable at address %h came while an access was pending",
                             addr_s);
                    protocol_err = 1'b1;
                end
                if (we_s && !en_s)
                begin
                    $display("target model: write enable at address %h came without enable",
                             addr_s);
                    protocol_err = 1'b1;
                end
                if (pending)
                begin
                    cnt = cnt - 1;
                    if (cnt == 0)
                    begin
                        if (acc_we)
                            mem[acc_addr] = acc_di;
                        else
                            drp_do = mem[acc_addr];
                        drp_rdy = 1'b1;   // one cycle only
                        pending = 1'b0;
                    end
                end
                if (en_s)
                begin
                    acc_we   = we_s;
                    acc_addr = addr_s;
                    acc_di   = di_s;
                    cnt      = 1 + int'({$random(seed)} % MAX_DELAY);
                    pending  = 1'b1;
                end
            end
        end
    end

endmodule

//--- tb/tb_gt_drp_subsys.sv
`timescale 1ns/1ps

module tb_gt_drp_subsys;

    localparam int LANES         = 2;
    localparam int LOAD_CNT_MAX  = 1;
    localparam int AW            = drp_pkg::DRP_ADDR_W;
    localparam int DW            = drp_pkg::DRP_DATA_W;
    localparam int MAX_DELAY     = 6;
    localparam int RANDOM_ROUNDS = 20;
    localparam int NUM_TESTS     = 4 + RANDOM_ROUNDS;
    // worst case for one field of one lane is load and grant, two strobes and two slow acks
    localparam int FIELD_CYCLES  = (LOAD_CNT_MAX + 2) + 3 + 2 * (MAX_DELAY + 3);
    localparam int TEST_CYCLES   = drp_pkg::FIELD_COUNT * LANES * FIELD_CYCLES + 60;
    localparam int WATCHDOG_NS   = (NUM_TESTS * TEST_CYCLES + 8 + 100) * 10;

    logic                           DRP_CLK = 1'b0;
    logic                           DRP_RST_N;
    logic [LANES-1:0]               start;
    logic [LANES-1:0]               x16;
    logic [DW-1:0]                  drp_do;
    logic                           drp_rdy;
    logic [AW-1:0]                  drp_addr;
    logic                           drp_en;
    logic [DW-1:0]                  drp_di;
    logic                           drp_we;
    logic [LANES-1:0]               done;
    drp_pkg::drp_state_e [LANES-1:0] lane_state;
    logic                           bd_we;
    logic [AW-1:0]                  bd_addr;
    logic [DW-1:0]                  bd_data;
    logic                           protocol_err;

    int               seed = 32'h2e07_5afc;
    logic             start_seen;
    bit               round_pending;
    string            round_name;
    logic [LANES-1:0] round_lanes;
    logic [LANES-1:0] round_sel;
    logic [DW-1:0]    prior [LANES][drp_pkg::FIELD_COUNT];

    always #5 DRP_CLK = ~DRP_CLK;

    gt_drp_subsys #
    (
        .LANES        (LANES),
        .LOAD_CNT_MAX (LOAD_CNT_MAX)
    )
    uut
    (
        .DRP_CLK      (DRP_CLK),
        .DRP_RST_N    (DRP_RST_N),
        .start        (start),
        .x16          (x16),
        .drp_do       (drp_do),
        .drp_rdy      (drp_rdy),
        .drp_addr     (drp_addr),
        .drp_en       (drp_en),
        .drp_di       (drp_di),
        .drp_we       (drp_we),
        .done         (done),
        .lane_state   (lane_state)
    );

    drp_target_model #
    (
        .SEED         (32'h2e07_5afc),
        .MAX_DELAY    (MAX_DELAY)
    )
    u_target
    (
        .DRP_CLK      (DRP_CLK),
        .DRP_RST_N    (DRP_RST_N),
        .drp_addr     (drp_addr),
        .drp_en       (drp_en),
        .drp_di       (drp_di),
        .drp_we       (drp_we),
        .bd_we        (bd_we),
        .bd_addr      (bd_addr),
        .bd_data      (bd_data),
        .drp_do       (drp_do),
        .drp_rdy      (drp_rdy),
        .protocol_err (protocol_err)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and checks
    function automatic logic [DW-1:0] ref_word(input logic [DW-1:0] old_word, input int field,
                                               input logic sel_x16);
        logic [DW-1:0] mask;
        logic [DW-1:0] x20_bits;
        mask     = (field == 0) ? drp_pkg::RX_DATAWIDTH_MASK : drp_pkg::TX_DATAWIDTH_MASK;
        x20_bits = (field == 0) ? drp_pkg::RX_X20_BITS : drp_pkg::TX_X20_BITS;
        return sel_x16 ? (old_word & mask) : ((old_word & mask) | x20_bits);  // x16 clears the bit
    endfunction

    function automatic logic [AW-1:0] field_addr(input int lane, input int field);
        logic [AW-1:0] ofs;
        ofs = (field == 0) ? drp_pkg::RX_DATAWIDTH_OFS : drp_pkg::TX_DATAWIDTH_OFS;
        return AW'(lane * int'(drp_pkg::LANE_SPAN)) + ofs;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [DW-1:0] expected,
                              input logic [DW-1:0] actual);
        if (actual !== expected)
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic check_state(input string name, input drp_pkg::drp_state_e expected,
                               input drp_pkg::drp_state_e actual);
        if (actual !== expected)
            abort_run($sformatf("[ERROR] %s: expected %s, actual %s", name, expected.name(),
                                actual.name()));
    endtask

    task automatic check_done(input string name, input logic [LANES-1:0] expected,
                              input logic [LANES-1:0] actual);
        if (actual !== expected)
            abort_run($sformatf("[ERROR] %s: expected done %b, actual %b", name, expected, actual));
    endtask

    always @(posedge DRP_CLK)
    begin
        if (DRP_RST_N === 1'b1 && !start_seen && (drp_en === 1'b1 || drp_we === 1'b1))
            abort_run("DRP enable or write enable was seen before any start was given");
        if (protocol_err === 1'b1)
            abort_run("the DRP target saw an overlapping or malformed access");
    end

    // waits for the started lanes to finish, then checks the target memory
    always
    begin : compare_round
        logic [DW-1:0] expected;
        wait (round_pending);
        while ((done & round_lanes) != '0)
            @(posedge DRP_CLK);
        while ((done & round_lanes) != round_lanes)
            @(posedge DRP_CLK);
        // a start taken while busy would pull the lane out of idle here
        repeat (6)
        begin
            @(posedge DRP_CLK);
            for (int l = 0; l < LANES; l++)
                check_state(round_name, drp_pkg::st_idle, lane_state[l]);
        end
        for (int l = 0; l < LANES; l++)
        begin
            for (int f = 0; f < drp_pkg::FIELD_COUNT; f++)
            begin
                expected = round_lanes[l] ? ref_word(prior[l][f], f, round_sel[l]) : prior[l][f];
                check_word(round_name, expected, u_target.mem[field_addr(l, f)]);
            end
        end
        check_done(round_name, {LANES{1'b1}}, done);
        round_pending = 1'b0;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    task automatic step();
        @(posedge DRP_CLK);
        #1;
    endtask

    task automatic poke(input logic [AW-1:0] addr, input logic [DW-1:0] data);
        bd_we   = 1'b1;
        bd_addr = addr;
        bd_data = data;
        step();
        bd_we   = 1'b0;
    endtask

    task automatic run_round(input string name, input logic [LANES-1:0] lanes,
                             input logic [LANES-1:0] sel, input logic restart);
        logic [DW-1:0] word;
        for (int l = 0; l < LANES; l++)
        begin
            for (int f = 0; f < drp_pkg::FIELD_COUNT; f++)
            begin
                word        = DW'($random(seed));
                prior[l][f] = word;
                poke(field_addr(l, f), word);
            end
        end
        x16 = sel;
        repeat (3) step();   // width select through its input flops before the start
        round_name    = name;
        round_lanes   = lanes;
        round_sel     = sel;
        round_pending = 1'b1;
        start         = lanes;
        start_seen    = 1'b1;
        step();
        start = '0;
        if (restart)
        begin
            while ((done & lanes) != '0)
                step();
            repeat (2) step();
            start = lanes;   // lanes are busy now
            step();
            start = '0;
        end
        wait (!round_pending);
        step();
    endtask

    initial
    begin : stimulus
        logic [LANES-1:0] lanes;
        logic [LANES-1:0] sel;
        DRP_RST_N     = 1'b0;
        start         = '0;
        x16           = '0;
        bd_we         = 1'b0;
        bd_addr       = '0;
        bd_data       = '0;
        start_seen    = 1'b0;
        round_pending = 1'b0;
        round_name    = "reset";
        round_lanes   = '0;
        round_sel     = '0;
        repeat (8) @(posedge DRP_CLK);
        #1;
        DRP_RST_N = 1'b1;
        repeat (10) step();
        check_done("reset", {LANES{1'b1}}, done);
        for (int l = 0; l < LANES; l++)
            check_state("reset", drp_pkg::st_idle, lane_state[l]);

        run_round("lane0_x16", 2'b01, 2'b01, 1'b0);
        run_round("lane0_x20", 2'b01, 2'b00, 1'b0);
        run_round("both_lanes", 2'b11, 2'b01, 1'b0);
        for (int r = 0; r < RANDOM_ROUNDS; r++)
        begin
            lanes = LANES'($random(seed));
            if (lanes == '0)
                lanes = 2'b10;
            sel = LANES'($random(seed));
            run_round($sformatf("random_%0d", r), lanes, sel, 1'($random(seed)));
        end
        $display("** PASS **");
        $finish;
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        abort_run($sformatf("timeout: the tests did not finish within %0d ns", WATCHDOG_NS));
    end

endmodule
